/* source/fetch_pkg.sv */
package fetch_pkg;

	// first fetch address, also the pc_reset target
	localparam logic [31:0] reset_vector = 32'h4000_0000;

	// add x0,x0,x0 shown to decode when no valid fetch
	localparam logic [31:0] nop_instr = 32'h0000_0033;

	// pc select from the later stages
	typedef enum logic [1:0]
	{
		pc_seq    = 2'b00,	// pc + 4
		pc_reset  = 2'b01,	// back to reset_vector
		pc_branch = 2'b10,	// taken branch or jump
		pc_hold   = 2'b11	// keep the current pc
	} pc_sel_t;

	// L1.5 fetch port FSM
	typedef enum logic [1:0]
	{
		st_req      = 2'b00,	// idle, request may go out
		st_wait_ack = 2'b01,	// header taken, waiting for ack
		st_resp     = 2'b10	// waiting for the fill return
	} port_state_t;

endpackage

/* source/l15_pkg.sv */
package l15_pkg;

	// request types, the front end only ever sends ifill
	typedef enum logic [4:0]
	{
		rq_ifill = 5'd0
	} l15_rqtype_t;

	// return types seen on l15_transducer_returntype
	typedef enum logic [3:0]
	{
		ret_load   = 4'd0,
		ret_ifill  = 4'd1,
		ret_st_ack = 4'd4,
		ret_int    = 4'd7	// wake-up interrupt
	} l15_rettype_t;

	// size field for an instruction fill, one 32-bit word
	localparam logic [2:0] l15_size_ifill = 3'b011;

endpackage

/* source/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen
(
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  stall,
	input  fetch_pkg::pc_sel_t    pcsel,
	input  logic [31:0]           target,
	input  logic [31:0]           epc,
	input  logic                  exception_pending,
	input  logic                  fetch_busy,
	input  logic                  fetch_done,
	output logic [31:0]           fetch_pc,
	output logic                  fetch_kill
);

	logic        redirect;	// some redirect requested this cycle
	logic [31:0] redirect_pc;
	logic        saved_valid;	// redirect waiting for the outstanding fetch
	logic [31:0] saved_pc;
	logic        advance;

	// exception wins over branch and reset
	always_comb
	begin
		redirect    = 1'b0;
		redirect_pc = target;
		if (exception_pending)
		begin
			redirect    = 1'b1;
			redirect_pc = epc;
		end
		else
		begin
			case (pcsel)
				fetch_pkg::pc_reset:
				begin
					redirect    = 1'b1;
					redirect_pc = fetch_pkg::reset_vector;
				end
				fetch_pkg::pc_branch:
				begin
					redirect    = 1'b1;
					redirect_pc = target;
				end
				fetch_pkg::pc_seq,
				fetch_pkg::pc_hold:
				begin
					redirect = 1'b0;
				end
			endcase
		end
	end

	// a stalled response is refetched, so the pc stays put
	assign advance = !stall && (pcsel != fetch_pkg::pc_hold);

	// also covers a redirect seen while idle, keeps the port from requesting
	assign fetch_kill = saved_valid || redirect;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			fetch_pc    <= fetch_pkg::reset_vector;
			saved_valid <= 1'b0;
		end
		else if (fetch_done)
		begin
			saved_valid <= 1'b0;
			if (redirect)
				fetch_pc <= redirect_pc;	// late redirect in the done cycle
			else if (saved_valid)
				fetch_pc <= saved_pc;
			else if (advance)
				fetch_pc <= fetch_pc + 32'd4;
		end
		else if (redirect)
		begin
			if (fetch_busy)
				saved_valid <= 1'b1;	// wait for the fetch in flight
			else
				fetch_pc <= redirect_pc;
		end
	end

	// latest redirect overrides an older saved one
	always_ff @(posedge clk)
	begin
		if (redirect && fetch_busy && !fetch_done)
			saved_pc <= redirect_pc;
	end

endmodule

/* source/l15_fetch_port.sv */
`timescale 1ns/1ps

module l15_fetch_port
(
	input  logic          clk,
	input  logic          nrst,
	input  logic          stall,
	input  logic [31:0]   fetch_pc,
	input  logic          fetch_kill,

	// L1.5 request side
	output logic          transducer_l15_val,
	output logic [4:0]    transducer_l15_rqtype,
	output logic [2:0]    transducer_l15_size,
	output logic [31:0]   transducer_l15_address,
	output logic [63:0]   transducer_l15_data,
	input  logic          l15_transducer_header_ack,
	input  logic          l15_transducer_ack,

	// L1.5 return side
	input  logic          l15_transducer_val,
	input  logic [3:0]    l15_transducer_returntype,
	input  logic [63:0]   l15_transducer_data_0,
	input  logic [63:0]   l15_transducer_data_1,
	output logic          transducer_l15_req_ack,

	output logic          fetch_busy,
	output logic          fetch_done,
	output logic          resp_strobe,
	output logic          resp_kill,
	output logic [31:0]   resp_pc,
	output logic [127:0]  resp_line
);

	fetch_pkg::port_state_t state;
	l15_pkg::l15_rettype_t  ret_type;
	logic                   wake_up;
	logic                   instr_ret;	// fill-class return
	logic                   req_fire;
	logic                   resp_accept;
	logic [31:0]            req_pc;

	assign ret_type  = l15_pkg::l15_rettype_t'(l15_transducer_returntype);
	assign instr_ret = (ret_type == l15_pkg::ret_ifill) || (ret_type == l15_pkg::ret_load);

	// no requests until the L1.5 sends its wake-up interrupt
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			wake_up <= 1'b0;
		else if (l15_transducer_val && (ret_type == l15_pkg::ret_int))
			wake_up <= 1'b1;
	end

	assign transducer_l15_val = (state == fetch_pkg::st_req) && wake_up && !stall && !fetch_kill;
	assign transducer_l15_rqtype  = l15_pkg::rq_ifill;
	assign transducer_l15_size    = l15_pkg::l15_size_ifill;
	assign transducer_l15_address = fetch_pc;
	assign transducer_l15_data    = 64'd0;	// fills carry no store data

	assign req_fire    = transducer_l15_val && l15_transducer_header_ack;
	assign resp_accept = (state == fetch_pkg::st_resp) && l15_transducer_val && instr_ret;

	// fills acked on accept, anything else acked on arrival
	assign transducer_l15_req_ack = resp_accept || (l15_transducer_val && !instr_ret);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			state <= fetch_pkg::st_req;
		else
		begin
			case (state)
				fetch_pkg::st_req:
					if (req_fire)
						state <= l15_transducer_ack ? fetch_pkg::st_resp : fetch_pkg::st_wait_ack;
				fetch_pkg::st_wait_ack:
					if (l15_transducer_ack)
						state <= fetch_pkg::st_resp;
				fetch_pkg::st_resp:
					if (resp_accept)
						state <= fetch_pkg::st_req;
				default:
					state <= fetch_pkg::st_req;
			endcase
		end
	end

	// address of the fetch in flight
	always_ff @(posedge clk)
	begin
		if (req_fire)
			req_pc <= fetch_pc;
	end

	assign fetch_busy  = (state != fetch_pkg::st_req);
	assign fetch_done  = resp_accept;
	assign resp_strobe = resp_accept;
	assign resp_kill   = fetch_kill || stall;	// overtaken or stalled, drop it
	assign resp_pc     = req_pc;
	assign resp_line   = {l15_transducer_data_0, l15_transducer_data_1};

endmodule

/* source/instr_align.sv */
`timescale 1ns/1ps

module instr_align
(
	input  logic          clk,
	input  logic          nrst,
	input  logic          resp_strobe,
	input  logic          resp_kill,
	input  logic [31:0]   resp_pc,
	input  logic [127:0]  resp_line,
	output logic [31:0]   pc2,
	output logic [31:0]   instr2,
	output logic          instr_valid,
	output logic          instruction_addr_misaligned
);

	logic [31:0] word_be;	// addressed word, big-endian
	logic [31:0] word_le;
	logic        deliver;

	// word 0 sits in the top bits of the line
	always_comb
	begin
		case (resp_pc[3:2])
			2'b00: word_be = resp_line[127:96];
			2'b01: word_be = resp_line[95:64];
			2'b10: word_be = resp_line[63:32];
			2'b11: word_be = resp_line[31:0];
		endcase
	end

	assign word_le = {word_be[7:0], word_be[15:8], word_be[23:16], word_be[31:24]};
	assign deliver = resp_strobe && !resp_kill;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc2                         <= fetch_pkg::reset_vector;
			instr2                      <= fetch_pkg::nop_instr;
			instr_valid                 <= 1'b0;
			instruction_addr_misaligned <= 1'b0;
		end
		else
		begin
			instr_valid                 <= deliver;	// one cycle only
			instr2                      <= deliver ? word_le : fetch_pkg::nop_instr;
			instruction_addr_misaligned <= deliver && (&resp_pc[1:0]);
			if (deliver)
				pc2 <= resp_pc;
		end
	end

endmodule

/* source/fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend
(
	input  logic                 clk,
	input  logic                 nrst,

	// from decode and later stages
	input  logic                 stall,
	input  fetch_pkg::pc_sel_t   pcsel,
	input  logic [31:0]          target,
	input  logic                 exception_pending,
	input  logic [31:0]          epc,

	// toward decode
	output logic [31:0]          pc2,
	output logic [31:0]          instr2,
	output logic                 instr_valid,
	output logic                 instruction_addr_misaligned,

	// L1.5 transducer
	output logic                 transducer_l15_val,
	output logic [4:0]           transducer_l15_rqtype,
	output logic [2:0]           transducer_l15_size,
	output logic [31:0]          transducer_l15_address,
	output logic [63:0]          transducer_l15_data,
	output logic                 transducer_l15_req_ack,
	input  logic                 l15_transducer_header_ack,
	input  logic                 l15_transducer_ack,
	input  logic                 l15_transducer_val,
	input  logic [3:0]           l15_transducer_returntype,
	input  logic [63:0]          l15_transducer_data_0,
	input  logic [63:0]          l15_transducer_data_1
);

	logic [31:0]  fetch_pc;
	logic         fetch_kill;
	logic         fetch_busy;
	logic         fetch_done;
	logic         resp_strobe;
	logic         resp_kill;
	logic [31:0]  resp_pc;
	logic [127:0] resp_line;

	pc_gen u_pc_gen
	(
		.clk               (clk),
		.nrst              (nrst),
		.stall             (stall),
		.pcsel             (pcsel),
		.target            (target),
		.epc               (epc),
		.exception_pending (exception_pending),
		.fetch_busy        (fetch_busy),
		.fetch_done        (fetch_done),
		.fetch_pc          (fetch_pc),
		.fetch_kill        (fetch_kill)
	);

	l15_fetch_port u_port
	(
		.clk                       (clk),
		.nrst                      (nrst),
		.stall                     (stall),
		.fetch_pc                  (fetch_pc),
		.fetch_kill                (fetch_kill),
		.transducer_l15_val        (transducer_l15_val),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_data       (transducer_l15_data),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_returntype (l15_transducer_returntype),
		.l15_transducer_data_0     (l15_transducer_data_0),
		.l15_transducer_data_1     (l15_transducer_data_1),
		.transducer_l15_req_ack    (transducer_l15_req_ack),
		.fetch_busy                (fetch_busy),
		.fetch_done                (fetch_done),
		.resp_strobe               (resp_strobe),
		.resp_kill                 (resp_kill),
		.resp_pc                   (resp_pc),
		.resp_line                 (resp_line)
	);

	instr_align u_align
	(
		.clk                         (clk),
		.nrst                        (nrst),
		.resp_strobe                 (resp_strobe),
		.resp_kill                   (resp_kill),
		.resp_pc                     (resp_pc),
		.resp_line                   (resp_line),
		.pc2                         (pc2),
		.instr2                      (instr2),
		.instr_valid                 (instr_valid),
		.instruction_addr_misaligned (instruction_addr_misaligned)
	);

endmodule

/* tb/fetch_frontend_checker.sv */
`timescale 1ns/1ps

module fetch_frontend_checker
(
	input logic               clk,
	input logic               nrst,
	input fetch_pkg::pc_sel_t pcsel,
	input logic               exception_pending,
	input logic               transducer_l15_val,
	input logic               l15_transducer_val,
	input logic [3:0]         l15_transducer_returntype,
	input logic               instr_valid
);

	logic        woke;	// wake-up interrupt seen
	int unsigned fail_count;	// failed assertions so far

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			woke <= 1'b0;
		else if (l15_transducer_val && l15_transducer_returntype == l15_pkg::ret_int)
			woke <= 1'b1;
	end

	no_req_before_wake: assert property (@(posedge clk) disable iff (!nrst)
		!woke |-> !transducer_l15_val)
		else
		begin
			$error("request issued before wake-up");
			fail_count = fail_count + 1;
		end

	valid_single_cycle: assert property (@(posedge clk) disable iff (!nrst)
		instr_valid |=> !instr_valid)
		else
		begin
			$error("instr_valid high two cycles in a row");
			fail_count = fail_count + 1;
		end

	// a redirect holds off any new request in its own cycle
	no_req_on_redirect: assert property (@(posedge clk) disable iff (!nrst)
		((pcsel == fetch_pkg::pc_branch || pcsel == fetch_pkg::pc_reset)
			&& !exception_pending) |-> !transducer_l15_val)
		else
		begin
			$error("request issued in the cycle of a redirect");
			fail_count = fail_count + 1;
		end

endmodule

bind fetch_frontend fetch_frontend_checker u_checker
(
	.clk                       (clk),
	.nrst                      (nrst),
	.pcsel                     (pcsel),
	.exception_pending         (exception_pending),
	.transducer_l15_val        (transducer_l15_val),
	.l15_transducer_val        (l15_transducer_val),
	.l15_transducer_returntype (l15_transducer_returntype),
	.instr_valid               (instr_valid)
);

/* tb/tb_fetch_frontend.sv */
`timescale 1ns/1ps

module tb_fetch_frontend;

	localparam int num_rows = 15;

	typedef struct
	{
		fetch_pkg::pc_sel_t pcsel;
		logic [31:0]        target;
		logic               exc;
		logic [31:0]        epc;
		logic               stall;
		logic               phase;	// 0 after the response, 1 while outstanding
		logic [31:0]        exp_addr;
		logic               exp_valid;
	} row_t;

	logic clk;
	logic nrst;
	logic stall;
	fetch_pkg::pc_sel_t pcsel;
	logic [31:0] target;
	logic exception_pending;
	logic [31:0] epc;
	logic [31:0] pc2;
	logic [31:0] instr2;
	logic instr_valid;
	logic instruction_addr_misaligned;
	logic transducer_l15_val;
	logic [4:0] transducer_l15_rqtype;
	logic [2:0] transducer_l15_size;
	logic [31:0] transducer_l15_address;
	logic [63:0] transducer_l15_data;
	logic transducer_l15_req_ack;
	logic l15_transducer_header_ack;
	logic l15_transducer_ack;
	logic l15_transducer_val;
	logic [3:0] l15_transducer_returntype;
	logic [63:0] l15_transducer_data_0;
	logic [63:0] l15_transducer_data_1;

	row_t rows [num_rows];
	int unsigned lcg_state = 32'd98602;

	fetch_frontend uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {17'd0, lcg_state[30:16]};
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(lcg_next() % (hi - lo + 1));
	endfunction

	// word k of the line holding addr
	function automatic logic [31:0] line_word(input logic [31:0] addr, input int k);
		return ({addr[31:4], 4'h0} + 32'(4 * k)) ^ 32'hA5A5_A5A5;
	endfunction

	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic set_row(input int i, input fetch_pkg::pc_sel_t sel, input logic [31:0] tgt,
		input logic exc, input logic [31:0] ep, input logic stl, input logic ph,
		input logic [31:0] addr, input logic vld);
		rows[i] = '{sel, tgt, exc, ep, stl, ph, addr, vld};
	endtask

	task automatic fail_run();
		$display("tests failed");
		$fatal(1);
	endtask

	// a non-fill return is acked in the cycle it is up
	task automatic check_nonfill_ack();
		assert (transducer_l15_req_ack)
		else
		begin
			$display("MISMATCH transducer_l15_req_ack got %h expected %h",
				transducer_l15_req_ack, 1'b1);
			fail_run();
		end
	endtask

	task automatic drive_row(input int i);
		pcsel             <= rows[i].pcsel;
		target            <= rows[i].target;
		exception_pending <= rows[i].exc;
		epc               <= rows[i].epc;
		stall             <= rows[i].stall;
	endtask

	task automatic idle_controls();
		pcsel             <= fetch_pkg::pc_seq;
		exception_pending <= 1'b0;
		stall             <= 1'b0;
	endtask

	// L1.5 responder, wake-up first, then fills with random delays
	initial
	begin
		int d_hdr;
		int d_ack;
		int lat;
		logic [31:0] a;
		@(posedge nrst);
		repeat (3) @(posedge clk);
		l15_transducer_val        <= 1'b1;
		l15_transducer_returntype <= l15_pkg::ret_int;
		@(posedge clk);
		check_nonfill_ack();
		l15_transducer_val <= 1'b0;
		forever
		begin
			@(posedge clk);
			if (transducer_l15_val)
			begin
				d_hdr = rand_range(0, 3);
				d_ack = rand_range(0, 3);
				lat   = rand_range(1, 6);
				repeat (d_hdr) @(posedge clk);
				l15_transducer_header_ack <= 1'b1;
				l15_transducer_ack        <= (d_ack == 0);
				do
					@(posedge clk);
				while (!(transducer_l15_val && l15_transducer_header_ack));
				a = transducer_l15_address;
				l15_transducer_header_ack <= 1'b0;
				l15_transducer_ack        <= 1'b0;
				if (d_ack > 0)
				begin
					repeat (d_ack - 1) @(posedge clk);
					l15_transducer_ack <= 1'b1;
					@(posedge clk);
					l15_transducer_ack <= 1'b0;
				end
				if (lcg_next() % 3 == 0)
				begin
					// store ack sneaking in ahead of the fill
					l15_transducer_val        <= 1'b1;
					l15_transducer_returntype <= l15_pkg::ret_st_ack;
					@(posedge clk);
					check_nonfill_ack();
					l15_transducer_val <= 1'b0;
				end
				repeat (lat) @(posedge clk);
				l15_transducer_val        <= 1'b1;
				l15_transducer_returntype <= l15_pkg::ret_ifill;
				l15_transducer_data_0     <= {line_word(a, 0), line_word(a, 1)};
				l15_transducer_data_1     <= {line_word(a, 2), line_word(a, 3)};
				do
					@(posedge clk);
				while (!transducer_l15_req_ack);
				l15_transducer_val    <= 1'b0;
				l15_transducer_data_0 <= 64'd0;
				l15_transducer_data_1 <= 64'd0;
			end
		end
	end

	always @(posedge clk)
	begin
		if (nrst)
			assert (!(transducer_l15_val && stall))
			else
			begin
				$display("request issued while stall was high");
				fail_run();
			end
	end

	initial
	begin
		repeat (num_rows * 40 + 200) @(posedge clk);
		$display("timeout: fetch front end stopped making progress");
		fail_run();
	end

	initial
	begin
		logic [31:0] addr;
		logic [31:0] exp_instr;
		stall = 1'b0;
		pcsel = fetch_pkg::pc_seq;
		target = 32'd0;
		exception_pending = 1'b0;
		epc = 32'd0;
		l15_transducer_header_ack = 1'b0;
		l15_transducer_ack = 1'b0;
		l15_transducer_val = 1'b0;
		l15_transducer_returntype = l15_pkg::ret_load;
		l15_transducer_data_0 = 64'd0;
		l15_transducer_data_1 = 64'd0;
		nrst = 1'b0;

		set_row(0, fetch_pkg::pc_seq, 0, 0, 0, 0, 0, fetch_pkg::reset_vector, 1);
		set_row(1, fetch_pkg::pc_seq, 0, 0, 0, 0, 0, 32'h4000_0004, 1);
		set_row(2, fetch_pkg::pc_branch, 32'h4000_0100, 0, 0, 0, 1, 32'h4000_0008, 0);
		set_row(3, fetch_pkg::pc_seq, 0, 0, 0, 0, 0, 32'h4000_0100, 1);
		set_row(4, fetch_pkg::pc_branch, 32'h4000_0200, 0, 0, 0, 0, 32'h4000_0104, 1);
		set_row(5, fetch_pkg::pc_reset, 0, 0, 0, 0, 0, 32'h4000_0200, 1);
		set_row(6, fetch_pkg::pc_seq, 0, 0, 0, 1, 1, 32'h4000_0000, 0);	// stalled response
		set_row(7, fetch_pkg::pc_seq, 0, 0, 0, 0, 0, 32'h4000_0000, 1);
		set_row(8, fetch_pkg::pc_branch, 32'h4000_0400, 1, 32'h4000_0300, 0, 0,
			32'h4000_0004, 1);
		set_row(9, fetch_pkg::pc_seq, 0, 0, 0, 0, 0, 32'h4000_0300, 1);
		set_row(10, fetch_pkg::pc_branch, 32'h4000_0503, 0, 0, 0, 0, 32'h4000_0304, 1);
		set_row(11, fetch_pkg::pc_seq, 0, 0, 0, 0, 0, 32'h4000_0503, 1);
		set_row(12, fetch_pkg::pc_seq, 0, 0, 0, 0, 0, 32'h4000_0507, 1);
		set_row(13, fetch_pkg::pc_branch, 32'h4000_0700, 1, 32'h4000_0600, 0, 1,
			32'h4000_050B, 0);
		set_row(14, fetch_pkg::pc_seq, 0, 0, 0, 0, 0, 32'h4000_0600, 1);

		repeat (8) @(posedge clk);
		nrst <= 1'b1;

		for (int i = 0; i < num_rows; i++)
		begin
			do
				@(posedge clk);
			while (!(transducer_l15_val && l15_transducer_header_ack));
			addr = transducer_l15_address;
			assert (addr == rows[i].exp_addr)
			else
			begin
				$display("MISMATCH row %0d transducer_l15_address got %h expected %h",
					i, addr, rows[i].exp_addr);
				fail_run();
			end
			assert (transducer_l15_rqtype == l15_pkg::rq_ifill)
			else
			begin
				$display("MISMATCH row %0d transducer_l15_rqtype got %h expected %h",
					i, transducer_l15_rqtype, l15_pkg::rq_ifill);
				fail_run();
			end
			assert (transducer_l15_size == l15_pkg::l15_size_ifill)
			else
			begin
				$display("MISMATCH row %0d transducer_l15_size got %h expected %h",
					i, transducer_l15_size, l15_pkg::l15_size_ifill);
				fail_run();
			end
			assert (transducer_l15_data == 64'd0)
			else
			begin
				$display("MISMATCH row %0d transducer_l15_data got %h expected %h",
					i, transducer_l15_data, 64'd0);
				fail_run();
			end
			if (rows[i].phase)
			begin
				drive_row(i);	// redirect or stall with the fetch in flight
				if (!rows[i].stall)
				begin
					@(posedge clk);
					idle_controls();
				end
			end
			do
				@(posedge clk);
			while (!(transducer_l15_req_ack && l15_transducer_val &&
				l15_transducer_returntype == l15_pkg::ret_ifill));
			if (!rows[i].phase)
				drive_row(i);
			@(posedge clk);
			if (!rows[i].phase)
				idle_controls();
			exp_instr = swap_bytes(line_word(rows[i].exp_addr, int'(rows[i].exp_addr[3:2])));
			assert (instr_valid == rows[i].exp_valid)
			else
			begin
				$display("MISMATCH row %0d instr_valid got %h expected %h",
					i, instr_valid, rows[i].exp_valid);
				fail_run();
			end
			if (rows[i].exp_valid)
			begin
				assert (pc2 == rows[i].exp_addr)
				else
				begin
					$display("MISMATCH row %0d pc2 got %h expected %h",
						i, pc2, rows[i].exp_addr);
					fail_run();
				end
				assert (instr2 == exp_instr)
				else
				begin
					$display("MISMATCH row %0d instr2 got %h expected %h",
						i, instr2, exp_instr);
					fail_run();
				end
				assert (instruction_addr_misaligned == (rows[i].exp_addr[1:0] == 2'b11))
				else
				begin
					$display("MISMATCH row %0d instruction_addr_misaligned got %h expected %h",
						i, instruction_addr_misaligned, (rows[i].exp_addr[1:0] == 2'b11));
					fail_run();
				end
			end
			else
			begin
				assert (instr2 == fetch_pkg::nop_instr)
				else
				begin
					$display("MISMATCH row %0d instr2 got %h expected %h",
						i, instr2, fetch_pkg::nop_instr);
					fail_run();
				end
			end
			if (rows[i].stall)
			begin
				repeat (3) @(posedge clk);	// stall lingers, no request may start
				idle_controls();
			end
		end

		if (uut.u_checker.fail_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* filelist.f */
source/fetch_pkg.sv
source/l15_pkg.sv
source/pc_gen.sv
source/l15_fetch_port.sv
source/instr_align.sv
source/fetch_frontend.sv
tb/fetch_frontend_checker.sv
tb/tb_fetch_frontend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "all tests passed" $(LOG); then \
		echo "simulation did not finish"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
